// File: Bender.yml
package:
  name: oflow_core

sources:
  # design, package first
  - hw/oflow_pkg.sv
  - hw/oflow_core_fsm.sv
  - hw/oflow_pe_array.sv
  - hw/oflow_history_buffer.sv
  - hw/oflow_conflict_resolve.sv
  - hw/oflow_result_writer.sv
  - hw/oflow_core_top.sv
  # verification
  - target: test
    files:
      - verif/oflow_core_assertions.sv
      - verif/oflow_core_tb.sv

// File: build.f
hw/oflow_pkg.sv
hw/oflow_core_fsm.sv
hw/oflow_pe_array.sv
hw/oflow_history_buffer.sv
hw/oflow_conflict_resolve.sv
hw/oflow_result_writer.sv
hw/oflow_core_top.sv
verif/oflow_core_assertions.sv
verif/oflow_core_tb.sv

// File: hw/oflow_conflict_resolve.sv
// conflict check on the frame just matched
// counts fresh identities in the current bank, rejects at the threshold
`timescale 1ns/1ps
`default_nettype none

module oflow_conflict_resolve import oflow_pkg::*; (
	input  logic                  clk,
	input  logic                  reset_N,
	input  logic                  start_cr,
	input  logic                  bank,
	input  logic [bbox_idx_w:0]   num_of_bbox_in_frame,
	input  mem_rsp_t              mem_rsp,
	output logic                  done_cr,      // frame may be committed
	output logic                  conflict_th,  // frame rejected
	output mem_req_t              mem_req
);

	typedef enum logic [1:0] {c_idle, c_rd, c_rwait} cr_state_t;

	cr_state_t             state;
	logic [bbox_idx_w-1:0] idx;
	logic [2:0]            fresh_cnt;  // stops at the threshold
	logic [2:0]            cnt_next;
	logic                  last_box;

	assign cnt_next = fresh_cnt + mem_rsp.rdata.fresh;
	assign last_box = ({1'b0, idx} == num_of_bbox_in_frame - 1'b1);
	assign mem_req  = '{req: (state == c_rd), we: 1'b0, addr: {bank, idx}, wdata: '0};

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			state       <= c_idle;
			idx         <= '0;
			fresh_cnt   <= '0;
			done_cr     <= 1'b0;
			conflict_th <= 1'b0;
		end else begin
			done_cr     <= 1'b0;
			conflict_th <= 1'b0;
			case (state)
				c_idle: if (start_cr) begin
					idx       <= '0;
					fresh_cnt <= '0;
					state     <= c_rd;
				end
				c_rd: if (mem_rsp.gnt)
					state <= c_rwait;
				c_rwait: if (mem_rsp.rvalid) begin
					fresh_cnt <= cnt_next;
					if (cnt_next >= oflow_pkg::conflict_th) begin
						conflict_th <= 1'b1;  // no need to scan further
						state       <= c_idle;
					end else if (last_box) begin
						done_cr <= 1'b1;
						state   <= c_idle;
					end else begin
						idx   <= idx + 1'b1;
						state <= c_rd;
					end
				end
				default: state <= c_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hw/oflow_core_fsm.sv
// frame sequencer for the tracker core
// counts sets against the frame size, numbers committed frames and
// issues the start strobes for matching, conflict check and write-out
`timescale 1ns/1ps
`default_nettype none

module oflow_core_fsm import oflow_pkg::*; (
	input  logic                   clk,
	input  logic                   reset_N,
	input  logic                   start,
	input  logic                   new_frame,
	input  logic [bbox_idx_w:0]    num_of_bbox_in_frame,  // 1..16
	input  logic                   set_valid,
	input  logic                   done_pe,
	input  logic                   done_cr,
	input  logic                   conflict_th,
	input  logic                   done_write,
	output logic                   ready_new_frame,
	output logic                   ready_new_set,
	output logic                   start_pe,
	output logic [set_cnt_w-1:0]   num_of_sets,
	output logic [set_cnt_w-1:0]   last_set_count,  // 1..4 boxes
	output logic                   start_cr,
	output logic                   start_write,
	output logic                   commit,
	output logic                   bank,
	output logic                   frame_done,
	output frame_status_t          frame_status
);

	// ------------------------------------------------------------------------
	// state and counters
	// ------------------------------------------------------------------------
	typedef enum logic [2:0] {
		idle_st,
		setup_st,  // one cycle, sizes are latched
		pe_st,
		cr_st,
		write_st
	} fsm_state_t;

	fsm_state_t             state;
	fsm_state_t             next_state;
	logic [set_cnt_w-1:0]   sets_taken;   // sets accepted so far
	logic                   set_pending;  // ready_new_set given, no set yet
	logic [frame_num_w-1:0] frame_num;
	logic                   all_sets_in;

	assign all_sets_in = (sets_taken == num_of_sets);
	assign bank        = frame_num[0];  // ping-pong on frame parity

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			state <= idle_st;
		end else begin
			state <= next_state;
		end
	end

	// ------------------------------------------------------------------------
	// next state and strobes
	// ------------------------------------------------------------------------
	always_comb begin
		next_state      = state;
		ready_new_frame = 1'b0;
		ready_new_set   = 1'b0;
		start_pe        = 1'b0;
		start_cr        = 1'b0;
		start_write     = 1'b0;
		commit          = 1'b0;
		case (state)
			idle_st: begin
				ready_new_frame = 1'b1;
				if (start || new_frame)  // both open a frame
					next_state = setup_st;
			end
			setup_st: begin
				start_pe      = 1'b1;
				ready_new_set = 1'b1;  // first set request
				next_state    = pe_st;
			end
			pe_st: begin
				if (done_pe) begin  // one done_pe per set
					if (!all_sets_in) begin
						ready_new_set = 1'b1;
					end else if (frame_num == '0) begin
						start_write = 1'b1;  // nothing to compare against
						next_state  = write_st;
					end else begin
						start_cr   = 1'b1;
						next_state = cr_st;
					end
				end
			end
			cr_st: begin
				if (conflict_th) begin
					next_state = idle_st;  // rejected, bank reused
				end else if (done_cr) begin
					start_write = 1'b1;
					next_state  = write_st;
				end
			end
			write_st: begin
				if (done_write) begin
					commit     = 1'b1;
					next_state = idle_st;
				end
			end
			default: next_state = idle_st;
		endcase
	end

	// ------------------------------------------------------------------------
	// sizes, set counting, frame numbering
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			num_of_sets    <= '0;
			last_set_count <= '0;
			sets_taken     <= '0;
			set_pending    <= 1'b0;
			frame_num      <= '0;
			frame_done     <= 1'b0;
			frame_status   <= '0;
		end else begin
			if (state == idle_st && (start || new_frame)) begin
				// ceil(n / 4) and n mod 4, a zero remainder means a full set
				num_of_sets    <= set_cnt_w'((num_of_bbox_in_frame + 5'd3) >> 2);
				last_set_count <= (num_of_bbox_in_frame[1:0] == 2'd0) ?
				                  set_cnt_w'(pe_num) : {1'b0, num_of_bbox_in_frame[1:0]};
			end
			if (state == setup_st)
				sets_taken <= '0;
			else if (set_valid && set_pending)
				sets_taken <= sets_taken + 1'b1;
			if (ready_new_set)
				set_pending <= 1'b1;
			else if (set_valid)
				set_pending <= 1'b0;  // stray set_valid is dropped
			if (commit)
				frame_num <= frame_num + 1'b1;
			// report one cycle after the frame ends either way
			frame_done <= commit || (state == cr_st && conflict_th);
			if (commit || (state == cr_st && conflict_th))
				frame_status <= '{committed: commit, frame_num: frame_num};
		end
	end

endmodule

`default_nettype wire

// File: hw/oflow_core_top.sv
// tracker core top level
// sequencer, matcher, resolver and writer around one history buffer
`timescale 1ns/1ps
`default_nettype none

module oflow_core_top import oflow_pkg::*; (
	input  logic                clk,
	input  logic                reset_N,
	input  logic                start,
	input  logic                new_frame,
	input  logic [bbox_idx_w:0] num_of_bbox_in_frame,
	input  logic                set_valid,
	input  set_t                set_in,
	output logic                ready_new_frame,
	output logic                ready_new_set,
	output logic                result_valid,
	output result_t             result,
	output logic                frame_done,
	output frame_status_t       frame_status
);

	logic                       start_pe;
	logic                       done_pe;
	logic [set_cnt_w-1:0]       num_of_sets;
	logic [set_cnt_w-1:0]       last_set_count;
	logic                       start_cr;
	logic                       done_cr;
	logic                       conflict_th;
	logic                       start_write;
	logic                       done_write;
	logic                       commit;
	logic                       bank;
	mem_req_t [client_num-1:0]  mem_req;  // 0 pe, 1 resolver, 2 writer
	mem_rsp_t [client_num-1:0]  mem_rsp;

	oflow_core_fsm u_fsm (
		.clk, .reset_N, .start, .new_frame, .num_of_bbox_in_frame, .set_valid,
		.done_pe, .done_cr, .conflict_th, .done_write,
		.ready_new_frame, .ready_new_set, .start_pe, .num_of_sets, .last_set_count,
		.start_cr, .start_write, .commit, .bank, .frame_done, .frame_status
	);

	oflow_pe_array u_pe (
		.clk, .reset_N, .start_pe, .num_of_sets, .last_set_count, .set_valid, .set_in,
		.bank, .commit, .mem_rsp(mem_rsp[0]), .done_pe, .mem_req(mem_req[0])
	);

	oflow_conflict_resolve u_cr (
		.clk, .reset_N, .start_cr, .bank, .num_of_bbox_in_frame,
		.mem_rsp(mem_rsp[1]), .done_cr, .conflict_th, .mem_req(mem_req[1])
	);

	oflow_result_writer u_wr (
		.clk, .reset_N, .start_write, .bank, .num_of_bbox_in_frame, .mem_rsp(mem_rsp[2]),
		.result_valid, .result, .done_write, .mem_req(mem_req[2])
	);

	oflow_history_buffer u_hist (
		.clk, .reset_N, .req(mem_req), .rsp(mem_rsp)
	);

endmodule

`default_nettype wire

// File: hw/oflow_history_buffer.sv
// two-bank history memory shared by three clients
// fixed priority grant, client 0 highest, registered read data
`timescale 1ns/1ps
`default_nettype none

module oflow_history_buffer import oflow_pkg::*; (
	input  logic                         clk,
	input  logic                         reset_N,
	input  mem_req_t [client_num-1:0]    req,
	output mem_rsp_t [client_num-1:0]    rsp
);

	hist_entry_t             mem [0:2**mem_addr_w-1];  // bank bit is the msb
	logic [client_num-1:0]   gnt;
	logic [client_num-1:0]   rvalid_q;
	mem_req_t                sel;                      // granted request
	hist_entry_t             rdata_q;

	// ------------------------------------------------------------------------
	// arbiter
	// ------------------------------------------------------------------------
	always_comb begin
		gnt = '0;
		sel = '0;
		for (int i = 0; i < client_num; i++) begin
			if (req[i].req && gnt == '0) begin  // first requester wins
				gnt[i] = 1'b1;
				sel    = req[i];
			end
		end
	end

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			rvalid_q <= '0;
		end else begin
			for (int i = 0; i < client_num; i++)
				rvalid_q[i] <= gnt[i] && !req[i].we;  // reads only
		end
	end

	// ------------------------------------------------------------------------
	// storage
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (sel.req) begin
			if (sel.we)
				mem[sel.addr] <= sel.wdata;
			else
				rdata_q <= mem[sel.addr];
		end
	end

	// read data is broadcast, rvalid tells the owner
	always_comb begin
		for (int i = 0; i < client_num; i++)
			rsp[i] = '{gnt: gnt[i], rvalid: rvalid_q[i], rdata: rdata_q};
	end

endmodule

`default_nettype wire

// File: hw/oflow_pe_array.sv
// box matcher for one set at a time
// each box is compared with the same index of the previous bank and
// written to the current bank with an inherited or a fresh identity
`timescale 1ns/1ps
`default_nettype none

module oflow_pe_array import oflow_pkg::*; (
	input  logic                 clk,
	input  logic                 reset_N,
	input  logic                 start_pe,
	input  logic [set_cnt_w-1:0] num_of_sets,
	input  logic [set_cnt_w-1:0] last_set_count,
	input  logic                 set_valid,
	input  set_t                 set_in,
	input  logic                 bank,
	input  logic                 commit,
	input  mem_rsp_t             mem_rsp,
	output logic                 done_pe,  // per set
	output mem_req_t             mem_req
);

	typedef enum logic [2:0] {p_idle, p_wait, p_look, p_rwait, p_wr} pe_state_t;

	pe_state_t                   state;
	set_t                        set_q;
	hist_entry_t                 entry_q;    // word to write back
	logic [set_cnt_w-1:0]        set_cnt;
	logic [1:0]                  lane;       // one of pe_num boxes
	logic [set_cnt_w-1:0]        set_boxes;  // boxes in the current set
	logic [bbox_idx_w-1:0]       idx;
	logic [1:0][max_bbox-1:0]    ent_valid;  // per bank, per box
	logic                        prev_valid;
	logic [id_w-1:0]             fresh_base; // first id not yet committed
	logic [id_w-1:0]             fresh_cnt;  // fresh ids in this frame
	logic [id_w-1:0]             fresh_id;
	bbox_t                       cur_box;
	logic                        match;
	logic                        take_fresh;
	logic                        last_set;

	assign cur_box    = set_q.box[lane];
	assign idx        = {set_cnt[1:0], lane};
	assign prev_valid = ent_valid[~bank][idx];
	assign last_set   = (set_cnt == num_of_sets - 1'b1);
	assign set_boxes  = last_set ? last_set_count : set_cnt_w'(pe_num);
	assign fresh_id   = fresh_base + fresh_cnt;
	assign match      = bbox_dist(cur_box, mem_rsp.rdata.box) <= match_dist;
	// no history entry, or history too far away
	assign take_fresh = (state == p_look && !prev_valid) ||
	                    (state == p_rwait && mem_rsp.rvalid && !match);

	// read previous bank in p_look, write current bank in p_wr
	always_comb begin
		mem_req       = '0;
		mem_req.addr  = {bank, idx};
		mem_req.wdata = entry_q;
		if (state == p_look && prev_valid) begin
			mem_req.req  = 1'b1;
			mem_req.addr = {~bank, idx};
		end else if (state == p_wr) begin
			mem_req.req = 1'b1;
			mem_req.we  = 1'b1;
		end
	end

	// ------------------------------------------------------------------------
	// control
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			state      <= p_idle;
			set_cnt    <= '0;
			lane       <= '0;
			ent_valid  <= '0;
			fresh_base <= '0;
			fresh_cnt  <= '0;
			done_pe    <= 1'b0;
		end else begin
			done_pe <= 1'b0;
			if (commit)
				fresh_base <= fresh_base + fresh_cnt;  // frame accepted
			if (take_fresh)
				fresh_cnt <= fresh_cnt + 1'b1;
			case (state)
				p_idle: if (start_pe) begin
					set_cnt         <= '0;
					fresh_cnt       <= '0;
					ent_valid[bank] <= '0;  // bank is rebuilt from scratch
					state           <= p_wait;
				end
				p_wait: if (set_valid) begin
					lane  <= '0;
					state <= p_look;
				end
				p_look: if (!prev_valid)
					state <= p_wr;
				else if (mem_rsp.gnt)
					state <= p_rwait;
				p_rwait: if (mem_rsp.rvalid)
					state <= p_wr;
				p_wr: if (mem_rsp.gnt) begin
					ent_valid[bank][idx] <= 1'b1;
					if ({1'b0, lane} == set_boxes - 1'b1) begin
						done_pe <= 1'b1;
						set_cnt <= set_cnt + 1'b1;
						state   <= last_set ? p_idle : p_wait;
					end else begin
						lane  <= lane + 1'b1;
						state <= p_look;
					end
				end
				default: state <= p_idle;
			endcase
		end
	end

	// set and entry payload
	always_ff @(posedge clk) begin
		if (state == p_wait && set_valid)
			set_q <= set_in;
		if (take_fresh)
			entry_q <= '{box: cur_box, id: fresh_id, fresh: 1'b1};
		else if (state == p_rwait && mem_rsp.rvalid)
			entry_q <= '{box: cur_box, id: mem_rsp.rdata.id, fresh: 1'b0};  // tracked
	end

endmodule

`default_nettype wire

// File: hw/oflow_pkg.sv
// optical-flow tracker core, shared constants and bus words
// history memory word, memory request/response, result stream word
`default_nettype none

package oflow_pkg;

	// ------------------------------------------------------------------------
	// sizes
	// ------------------------------------------------------------------------
	localparam int pe_num      = 4;   // boxes per set
	localparam int max_bbox    = 16;  // boxes per frame
	localparam int bbox_idx_w  = 4;
	localparam int set_cnt_w   = 3;   // holds 0..4 sets
	localparam int id_w        = 8;
	localparam int coord_w     = 8;
	localparam int score_w     = 9;   // |dx| + |dy| needs one extra bit
	localparam int match_dist  = 8;   // largest distance still tracked
	localparam int conflict_th = 4;   // fresh ids that reject a frame
	localparam int frame_num_w = 8;
	localparam int client_num  = 3;   // pe array, resolver, writer
	localparam int mem_addr_w  = 5;   // {bank, box index}

	// ------------------------------------------------------------------------
	// packed words
	// ------------------------------------------------------------------------
	typedef struct packed {
		logic [coord_w-1:0] x;
		logic [coord_w-1:0] y;
	} bbox_t;

	typedef struct packed {
		bbox_t [pe_num-1:0] box;  // box[0] is the lowest index of the set
	} set_t;

	typedef struct packed {
		bbox_t           box;
		logic [id_w-1:0] id;
		logic            fresh;  // id was newly issued in this frame
	} hist_entry_t;

	typedef struct packed {
		logic                  req;
		logic                  we;
		logic [mem_addr_w-1:0] addr;
		hist_entry_t           wdata;
	} mem_req_t;

	typedef struct packed {
		logic        gnt;
		logic        rvalid;  // one cycle after a read grant
		hist_entry_t rdata;
	} mem_rsp_t;

	typedef struct packed {
		logic [bbox_idx_w-1:0] idx;
		logic [id_w-1:0]       id;
		logic [score_w-1:0]    score;
		logic                  fresh;
	} result_t;

	typedef struct packed {
		logic                   committed;
		logic [frame_num_w-1:0] frame_num;
	} frame_status_t;

	// manhattan distance between two box corners
	function automatic logic [score_w-1:0] bbox_dist(input bbox_t a, input bbox_t b);
		logic [coord_w-1:0] dx;
		logic [coord_w-1:0] dy;
		dx = (a.x > b.x) ? a.x - b.x : b.x - a.x;
		dy = (a.y > b.y) ? a.y - b.y : b.y - a.y;
		return {1'b0, dx} + {1'b0, dy};
	endfunction

endpackage

`default_nettype wire

// File: hw/oflow_result_writer.sv
// result streamer for a committed frame
// reads the current bank in index order, tracked boxes also fetch the
// previous entry so that the score is the corner distance
`timescale 1ns/1ps
`default_nettype none

module oflow_result_writer import oflow_pkg::*; (
	input  logic                clk,
	input  logic                reset_N,
	input  logic                start_write,
	input  logic                bank,
	input  logic [bbox_idx_w:0] num_of_bbox_in_frame,
	input  mem_rsp_t            mem_rsp,
	output logic                result_valid,
	output result_t             result,
	output logic                done_write,
	output mem_req_t            mem_req
);

	typedef enum logic [2:0] {w_idle, w_rd_cur, w_cur, w_rd_prev, w_prev} wr_state_t;

	wr_state_t             state;
	logic [bbox_idx_w-1:0] idx;
	hist_entry_t           cur_q;
	logic                  last_box;
	logic                  emit;

	assign last_box = ({1'b0, idx} == num_of_bbox_in_frame - 1'b1);
	// fresh boxes go out right away with a zero score
	assign emit     = mem_rsp.rvalid &&
	                  ((state == w_cur && mem_rsp.rdata.fresh) || state == w_prev);

	always_comb begin
		mem_req      = '0;
		mem_req.req  = (state == w_rd_cur) || (state == w_rd_prev);
		mem_req.addr = {(state == w_rd_prev) ? ~bank : bank, idx};
	end

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			state        <= w_idle;
			idx          <= '0;
			result_valid <= 1'b0;
			done_write   <= 1'b0;
		end else begin
			result_valid <= emit;
			done_write   <= emit && last_box;
			case (state)
				w_idle: if (start_write) begin
					idx   <= '0;
					state <= w_rd_cur;
				end
				w_rd_cur:  if (mem_rsp.gnt) state <= w_cur;
				w_cur:     if (mem_rsp.rvalid && !mem_rsp.rdata.fresh) state <= w_rd_prev;
				w_rd_prev: if (mem_rsp.gnt) state <= w_prev;
				default: ;
			endcase
			if (emit) begin
				idx   <= idx + 1'b1;
				state <= last_box ? w_idle : w_rd_cur;
			end
		end
	end

	// result payload
	always_ff @(posedge clk) begin
		if (state == w_cur && mem_rsp.rvalid) begin
			cur_q  <= mem_rsp.rdata;
			result <= '{idx: idx, id: mem_rsp.rdata.id, score: '0, fresh: mem_rsp.rdata.fresh};
		end
		if (state == w_prev && mem_rsp.rvalid)
			result <= '{idx: idx, id: cur_q.id,
			           score: bbox_dist(cur_q.box, mem_rsp.rdata.box), fresh: 1'b0};
	end

endmodule

`default_nettype wire

// File: verif/oflow_core_assertions.sv
// protocol checkers for the tracker core
// bound to the frame sequencer and to the history buffer arbiter
// inputs that do not apply to a target are tied off
`timescale 1ns/1ps
`default_nettype none

module oflow_core_assertions import oflow_pkg::*; (
	input logic                  clk,
	input logic                  reset_N,
	input logic                  set_valid,
	input logic                  set_pending,
	input logic                  ready_new_frame,
	input logic                  in_idle,
	input logic [client_num-1:0] gnt,
	input logic [client_num-1:0] rvalid,
	input logic [client_num-1:0] we
);

	bit   gnt_err;
	bit   rvalid_err;
	bit   set_err;
	bit   ready_err;
	logic failed;  // any assertion has fired so far

	assign failed = gnt_err | rvalid_err | set_err | ready_err;

	// ------------------------------------------------------------------------
	// arbiter
	// ------------------------------------------------------------------------
	a_one_gnt: assert property (@(posedge clk) disable iff (!reset_N) $onehot0(gnt))
		else begin
			gnt_err = 1'b1;
			$error("more than one grant in a cycle");
		end

	// read data one cycle after a read grant and never otherwise
	a_rvalid: assert property (@(posedge clk) disable iff (!reset_N)
		rvalid == $past(gnt & ~we))
		else begin
			rvalid_err = 1'b1;
			$error("read valid not one cycle after its grant");
		end

	// ------------------------------------------------------------------------
	// sequencer
	// ------------------------------------------------------------------------
	a_set_pending: assert property (@(posedge clk) disable iff (!reset_N)
		set_valid |-> set_pending)
		else begin
			set_err = 1'b1;
			$error("set_valid without a pending ready_new_set");
		end

	a_ready_idle: assert property (@(posedge clk) disable iff (!reset_N)
		ready_new_frame |-> in_idle)
		else begin
			ready_err = 1'b1;
			$error("ready_new_frame high outside idle");
		end

endmodule

bind oflow_core_fsm oflow_core_assertions sva_fsm (
	.clk, .reset_N, .set_valid, .set_pending, .ready_new_frame,
	.in_idle(state == idle_st),
	.gnt('0), .rvalid('0), .we('0)
);

bind oflow_history_buffer oflow_core_assertions sva_hist (
	.clk, .reset_N,
	.set_valid(1'b0), .set_pending(1'b0), .ready_new_frame(1'b0), .in_idle(1'b1),
	.gnt, .rvalid(rvalid_q), .we({req[2].we, req[1].we, req[0].we})
);

`default_nettype wire

// File: verif/oflow_core_tb.sv
// testbench for the tracker core
// a frame table drives frames and box sets
// a reference model predicts every result word and frame status
`timescale 1ns/1ps
`default_nettype none

module oflow_core_tb import oflow_pkg::*; ();

	typedef struct packed {
		logic [bbox_idx_w:0] nbox;
		logic [15:0]         jump;    // boxes moved far from last committed frame
		logic                commit;  // expected outcome
	} frame_row_t;

	// ------------------------------------------------------------------------
	// frame table
	// ------------------------------------------------------------------------
	frame_row_t frame_tab [0:11] = '{
		'{5'd7,  16'h0000, 1'b1},  // first frame with ids 0..6 all fresh
		'{5'd7,  16'h0000, 1'b1},  // small moves keep every id
		'{5'd9,  16'h0004, 1'b1},  // box 2 jumps and boxes 7 and 8 are new
		'{5'd9,  16'h000f, 1'b0},  // four jumps reject the frame
		'{5'd9,  16'h0020, 1'b1},  // matched against frame 2 again
		'{5'd12, 16'h0000, 1'b1},
		'{5'd15, 16'h0000, 1'b1},
		'{5'd16, 16'h0000, 1'b1},  // four full sets
		'{5'd1,  16'h0000, 1'b1},  // single box
		'{5'd4,  16'h0000, 1'b1},  // one full set
		'{5'd16, 16'h0000, 1'b0},  // twelve new boxes
		'{5'd4,  16'h0000, 1'b1}
	};

	logic                clk;
	logic                reset_N;
	logic                start;
	logic                new_frame;
	logic [bbox_idx_w:0] num_of_bbox_in_frame;
	logic                set_valid;
	set_t                set_in;
	logic                ready_new_frame;
	logic                ready_new_set;
	logic                result_valid;
	result_t             result;
	logic                frame_done;
	frame_status_t       frame_status;

	// reference model state for the last committed frame and the frame in flight
	logic [coord_w-1:0]  hist_x [max_bbox];
	logic [coord_w-1:0]  hist_y [max_bbox];
	logic [id_w-1:0]     hist_id [max_bbox];
	logic [coord_w-1:0]  cur_x [max_bbox];
	logic [coord_w-1:0]  cur_y [max_bbox];
	int                  hist_n;
	int                  fresh_base;
	int                  frame_num;
	logic [31:0]         lcg_state = 32'h2849_0930;
	result_t             exp_q [$];
	result_t             got_q [$];  // filled by the monitor
	int                  set_strobes;

	oflow_core_top uut (
		.clk, .reset_N, .start, .new_frame, .num_of_bbox_in_frame, .set_valid, .set_in,
		.ready_new_frame, .ready_new_set, .result_valid, .result, .frame_done, .frame_status
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// outputs sampled mid-cycle
	always @(negedge clk) begin
		if (reset_N) begin
			if (ready_new_set)
				set_strobes++;
			if (result_valid)
				got_q.push_back(result);
		end
	end

	// stop at the first flagged assertion
	always @(negedge clk) begin
		if (uut.u_fsm.sva_fsm.failed || uut.u_hist.sva_hist.failed) begin
			$display("an assertion on the FSM or the arbiter failed during the run");
			$display("Result: FAILED");
			$fatal(1, "assertion failure");
		end
	end

	// ------------------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------------------
	function automatic logic [7:0] rand_byte();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[23:16];
	endfunction

	function automatic int abs_diff(input int a, input int b);
		return (a > b) ? a - b : b - a;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
			$display("Result: FAILED");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	task automatic report_timeout(input string what);
		$display("timeout: %s never came", what);
		$display("Result: FAILED");
		$fatal(1, "wait limit reached");
	endtask

	task automatic wait_ready_frame();
		int cycles;
		for (cycles = 0; cycles < 4000; cycles++) begin
			@(negedge clk);
			if (ready_new_frame)
				break;
		end
		if (cycles == 4000)
			report_timeout("ready_new_frame");
	endtask

	task automatic wait_ready_set();
		int cycles;
		for (cycles = 0; cycles < 4000; cycles++) begin
			@(negedge clk);
			if (ready_new_set)
				break;
		end
		if (cycles == 4000)
			report_timeout("ready_new_set for the next box set");
	endtask

	task automatic wait_frame_done();
		int cycles;
		for (cycles = 0; cycles < 4000; cycles++) begin
			@(negedge clk);
			if (frame_done)
				break;
		end
		if (cycles == 4000)
			report_timeout("frame_done");
	endtask

	// coordinates of frame f and the predicted results
	task automatic make_frame(input int f, output logic commit_exp, output int fresh_cnt);
		int      n;
		int      dx;
		int      dy;
		int      d;
		result_t r;
		n         = int'(frame_tab[f].nbox);
		fresh_cnt = 0;
		exp_q.delete();
		for (int i = 0; i < n; i++) begin
			dx = int'(rand_byte()) % 5;  // at most 8 in total
			dy = int'(rand_byte()) % 5;
			d  = 0;
			if (i < hist_n && frame_tab[f].jump[i]) begin
				cur_x[i] = hist_x[i] ^ 8'h80;  // far jump
				cur_y[i] = hist_y[i] ^ 8'h80;
			end else if (i < hist_n) begin
				cur_x[i] = (hist_x[i] < 8'd128) ? hist_x[i] + 8'(dx) : hist_x[i] - 8'(dx);
				cur_y[i] = (hist_y[i] < 8'd128) ? hist_y[i] + 8'(dy) : hist_y[i] - 8'(dy);
			end else if (f == 0) begin
				cur_x[i] = 8'(20 + 28 * i);  // fixed first frame
				cur_y[i] = 8'(30 + 12 * i);
			end else begin
				cur_x[i] = rand_byte();
				cur_y[i] = rand_byte();
			end
			if (i < hist_n)
				d = abs_diff(cur_x[i], hist_x[i]) + abs_diff(cur_y[i], hist_y[i]);
			if (i < hist_n && d <= match_dist) begin
				r = '{idx: bbox_idx_w'(i), id: hist_id[i], score: score_w'(d), fresh: 1'b0};
			end else begin
				r = '{idx: bbox_idx_w'(i), id: id_w'(fresh_base + fresh_cnt), score: '0,
				      fresh: 1'b1};
				fresh_cnt++;
			end
			exp_q.push_back(r);
		end
		// frame 0 skips the conflict check
		commit_exp = (frame_num == 0) || (fresh_cnt < conflict_th);
	endtask

	task automatic run_frame(input int f);
		int   n;
		int   sets;
		int   fresh_cnt;
		logic commit_exp;
		set_t word;
		n    = int'(frame_tab[f].nbox);
		sets = (n + pe_num - 1) / pe_num;
		make_frame(f, commit_exp, fresh_cnt);
		check_value("model commit", 32'(commit_exp), 32'(frame_tab[f].commit));
		wait_ready_frame();
		@(posedge clk);
		set_strobes = 0;
		got_q.delete();
		num_of_bbox_in_frame <= (bbox_idx_w + 1)'(n);
		if (f == 0)
			start <= 1'b1;
		else
			new_frame <= 1'b1;
		@(posedge clk);
		start     <= 1'b0;
		new_frame <= 1'b0;
		for (int s = 0; s < sets; s++) begin
			word = '0;
			for (int l = 0; l < pe_num; l++)
				if (s * pe_num + l < n)
					word.box[l] = '{x: cur_x[s * pe_num + l], y: cur_y[s * pe_num + l]};
			wait_ready_set();
			@(posedge clk);
			set_in    <= word;
			set_valid <= 1'b1;
			@(posedge clk);
			set_valid <= 1'b0;
		end
		wait_frame_done();
		check_value("frame_status.committed", 32'(frame_status.committed),
		            32'(frame_tab[f].commit));
		check_value("frame_status", 32'(frame_status),
		            32'({commit_exp, frame_num_w'(frame_num)}));
		check_value("ready_new_set strobes", 32'(set_strobes), 32'(sets));
		check_value("result count", 32'(got_q.size()), commit_exp ? 32'(n) : 32'd0);
		if (commit_exp) begin
			for (int i = 0; i < n; i++) begin
				check_value($sformatf("result[%0d]", i), 32'(got_q[i]), 32'(exp_q[i]));
				hist_x[i]  = cur_x[i];
				hist_y[i]  = cur_y[i];
				hist_id[i] = exp_q[i].id;
			end
			hist_n     = n;
			fresh_base = fresh_base + fresh_cnt;
			frame_num  = frame_num + 1;
		end
	endtask

	// ------------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------------
	initial begin
		reset_N              = 1'b0;
		start                = 1'b0;
		new_frame            = 1'b0;
		num_of_bbox_in_frame = '0;
		set_valid            = 1'b0;
		set_in               = '0;
		hist_n               = 0;
		fresh_base           = 0;
		frame_num            = 0;
		set_strobes          = 0;
		repeat (16) @(posedge clk);
		reset_N <= 1'b1;
		@(negedge clk);
		check_value("ready_new_frame", 32'(ready_new_frame), 32'd1);  // idle after reset
		check_value("ready_new_set", 32'(ready_new_set), 32'd0);
		check_value("result_valid", 32'(result_valid), 32'd0);
		check_value("frame_done", 32'(frame_done), 32'd0);
		check_value("frame_status", 32'(frame_status), 32'd0);
		for (int f = 0; f < $size(frame_tab); f++)
			run_frame(f);
		repeat (4) @(negedge clk);
		if (uut.u_fsm.sva_fsm.failed || uut.u_hist.sva_hist.failed) begin
			$display("an assertion on the FSM or the arbiter failed during the run");
			$display("Result: FAILED");
			$fatal(1, "assertion failure");
		end else begin
			$display("Result: PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire
